// ==== flist.f ====
+incdir+source
source/rob_pkg.sv
source/rob_if.sv
source/rob_ptr_ctr.sv
source/rob_entry_store.sv
source/rob_commit_fsm.sv
source/arch_regfile.sv
source/rob_top.sv
verification/rob_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rob_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int MAX_CYCLES = 4000;

    typedef struct packed {
        entry_kind_e            kind;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   mis;
        logic [`XLEN-1:0]       val;
    } ref_t;

    logic                   clk;
    logic                   rst_n;
    logic                   alloc_valid;
    entry_kind_e            alloc_kind;
    logic [`REG_ADDR_W-1:0] alloc_rd;
    logic                   alloc_ready;
    logic [`ROB_TAG_W-1:0]  alloc_tag;
    logic                   wb_valid;
    logic [`ROB_TAG_W-1:0]  wb_tag;
    logic [`XLEN-1:0]       wb_result;
    logic                   wb_mispredict;
    logic                   commit_valid;
    logic [`REG_ADDR_W-1:0] commit_rd;
    logic [`XLEN-1:0]       commit_data;
    logic                   redirect_valid;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   st_req;
    logic [`XLEN-1:0]       st_data;
    logic                   st_ack;
    logic [`REG_ADDR_W-1:0] rf_rd_addr;
    logic [`XLEN-1:0]       rf_rd_data;

    // reference model, entries in program order
    ref_t                   ref_q[$];
    ref_t                   ref_head;
    logic                   ref_any;
    logic                   ack_d;
    logic [`XLEN-1:0]       shadow [`NUM_REGS];
    logic [`XLEN-1:0]       wb_val_by_tag [`ROB_DEPTH];
    logic                   wb_mis_by_tag [`ROB_DEPTH];
    logic [`ROB_TAG_W-1:0]  pend[$];
    logic [31:0]            lfsr;
    int                     cycles;
    int                     allocs;
    int                     errors;
    int                     errors_at_start;
    int                     tests;
    int                     failed;
    int                     stores_done;
    int                     stores_start;
    int                     redirects;
    int                     redirects_start;
    string                  cur_test;

    rob_top UUT (.*);

    always #20 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic void value_error(string what, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("[FAIL] %s: %s expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
    endfunction

    function automatic void plain_error(string msg);
        errors++;
        $display("ERROR in %s: %s", cur_test, msg);
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // follows retirement as seen at the ports
    always @(negedge clk) begin : ref_model
        ref_t front;
        ref_t retired;
        logic any;
        front = '0;
        any = 1'b0;
        if (rst_n) begin
            if (commit_valid && ref_q.size() > 0) begin
                retired = ref_q.pop_front();
                // x0 ignores writes
                if (retired.rd != '0) begin
                    shadow[retired.rd] = retired.val;
                end
            end
            if (redirect_valid) begin
                redirects++;
                ref_q.delete();
            end
            if (ack_d && !st_ack) begin
                stores_done++;
                if (ref_q.size() > 0) begin
                    ref_q.pop_front();
                end
            end
            ack_d = st_ack;
            // correct branches retire without a trace at the ports
            while (ref_q.size() > 0 && ref_q[0].kind == KIND_BRANCH && !ref_q[0].mis) begin
                ref_q.pop_front();
            end
            if (ref_q.size() > 0) begin
                any = 1'b1;
                front = ref_q[0];
            end
        end
        ref_any  <= any;
        ref_head <= front;
    end

    a_commit_head: assert property (@(negedge clk) disable iff (!rst_n)
        commit_valid |-> ref_any && ref_head.kind == KIND_REG)
        else plain_error("commit while the oldest entry is not a register entry");
    a_commit_rd: assert property (@(negedge clk) disable iff (!rst_n)
        commit_valid && ref_any |-> commit_rd == ref_head.rd)
        else value_error("commit_rd", 32'($sampled(ref_head.rd)), 32'($sampled(commit_rd)));
    a_commit_data: assert property (@(negedge clk) disable iff (!rst_n)
        commit_valid && ref_any |-> commit_data == ref_head.val)
        else value_error("commit_data", $sampled(ref_head.val), $sampled(commit_data));
    a_redirect_head: assert property (@(negedge clk) disable iff (!rst_n)
        redirect_valid |-> ref_any && ref_head.kind == KIND_BRANCH && ref_head.mis)
        else plain_error("redirect without a mispredicted branch at the head");
    a_redirect_pc: assert property (@(negedge clk) disable iff (!rst_n)
        redirect_valid && ref_any |-> redirect_pc == ref_head.val)
        else value_error("redirect_pc", $sampled(ref_head.val), $sampled(redirect_pc));
    a_redirect_pulse: assert property (@(negedge clk) disable iff (!rst_n)
        $past(redirect_valid) |-> !redirect_valid)
        else plain_error("redirect_valid stayed high for more than one cycle");
    a_store_head: assert property (@(negedge clk) disable iff (!rst_n)
        st_req |-> ref_any && ref_head.kind == KIND_STORE)
        else plain_error("st_req while the oldest entry is not a store");
    a_store_data: assert property (@(negedge clk) disable iff (!rst_n)
        st_req && ref_any |-> st_data == ref_head.val)
        else value_error("st_data", $sampled(ref_head.val), $sampled(st_data));
    a_store_hold: assert property (@(negedge clk) disable iff (!rst_n)
        $past(st_req) && !$past(st_ack) |-> st_req)
        else plain_error("st_req dropped before st_ack");
    a_store_drop: assert property (@(negedge clk) disable iff (!rst_n)
        $past(st_req) && $past(st_ack) |-> !st_req)
        else plain_error("st_req still high after st_ack");
    a_store_quiet: assert property (@(negedge clk) disable iff (!rst_n)
        (st_req || st_ack) |-> !commit_valid)
        else plain_error("commit during a store handshake");

    // memory side of the store port
    always begin : mem_model
        int unsigned dly;
        @(negedge clk);
        if (st_req && !st_ack) begin
            dly = lfsr_bits(2);
            repeat (dly) @(negedge clk);
            next_cycle();
            st_ack = 1'b1;
            @(negedge clk);
            while (st_req) begin
                @(negedge clk);
            end
            dly = lfsr_bits(2);
            repeat (dly) @(negedge clk);
            next_cycle();
            st_ack = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic alloc_one(input entry_kind_e kind, input logic [`REG_ADDR_W-1:0] rd,
                             input logic mis);
        ref_t e;
        logic [`ROB_TAG_W-1:0] tag;
        logic fired;
        e.kind = kind;
        e.rd = rd;
        e.mis = mis;
        e.val = lfsr_bits(32);
        alloc_valid = 1'b1;
        alloc_kind = kind;
        alloc_rd = rd;
        fired = 1'b0;
        while (!fired) begin
            @(negedge clk);
            fired = alloc_ready;
            tag = alloc_tag;
            next_cycle();
        end
        alloc_valid = 1'b0;
        // tail moves once per allocation and wraps, a flush leaves it alone
        assert (tag == `ROB_TAG_W'(allocs % `ROB_DEPTH))
            else value_error("alloc_tag", 32'(allocs % `ROB_DEPTH), 32'(tag));
        allocs++;
        ref_q.push_back(e);
        wb_val_by_tag[tag] = e.val;
        wb_mis_by_tag[tag] = mis;
        pend.push_back(tag);
    endtask

    task automatic writeback_at(input int idx);
        logic [`ROB_TAG_W-1:0] tag;
        tag = pend[idx];
        pend.delete(idx);
        wb_valid = 1'b1;
        wb_tag = tag;
        wb_result = wb_val_by_tag[tag];
        wb_mispredict = wb_mis_by_tag[tag];
        next_cycle();
        wb_valid = 1'b0;
    endtask

    task automatic writeback_shuffled();
        while (pend.size() > 0) begin
            writeback_at(int'(lfsr_bits(4)) % pend.size());
        end
    endtask

    task automatic wait_drain();
        while (ref_q.size() > 0 || st_req || st_ack) begin
            next_cycle();
        end
        repeat (3) next_cycle();
    endtask

    task automatic check_regfile();
        for (int r = 0; r < `NUM_REGS; r++) begin
            rf_rd_addr = `REG_ADDR_W'(r);
            @(negedge clk);
            assert (rf_rd_data == shadow[r])
                else value_error($sformatf("x%0d", r), shadow[r], rf_rd_data);
            next_cycle();
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        if (errors == errors_at_start) begin
            $display("test %-8s ok", cur_test);
        end else begin
            failed++;
            $display("test %-8s FAILED with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        alloc_valid = 1'b0;
        alloc_kind = KIND_REG;
        alloc_rd = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_result = '0;
        wb_mispredict = 1'b0;
        st_ack = 1'b0;
        rf_rd_addr = '0;
        lfsr = 32'h8278eec9;
        cycles = 0;
        allocs = 0;
        errors = 0;
        tests = 0;
        failed = 0;
        stores_done = 0;
        redirects = 0;
        ack_d = 1'b0;
        ref_any = 1'b0;
        ref_head = '0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start_test("reset");
        repeat (4) begin
            @(negedge clk);
            assert (!commit_valid && !redirect_valid && !st_req)
                else plain_error("commit, redirect or st_req high before any allocation");
            assert (alloc_ready) else plain_error("alloc_ready low after reset");
            next_cycle();
        end
        check_regfile();
        finish_test();

        // small rd range so that registers get overwritten
        start_test("in_order");
        alloc_one(KIND_REG, '0, 1'b0);
        for (int i = 1; i < 12; i++) begin
            alloc_one(KIND_REG, `REG_ADDR_W'(lfsr_bits(3)), 1'b0);
        end
        writeback_shuffled();
        wait_drain();
        check_regfile();
        finish_test();

        start_test("full");
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            alloc_one(KIND_REG, `REG_ADDR_W'(lfsr_bits(3)), 1'b0);
        end
        @(negedge clk);
        assert (!alloc_ready) else plain_error("alloc_ready high with every entry in use");
        next_cycle();
        writeback_at(0);
        while (!alloc_ready) begin
            next_cycle();
        end
        alloc_one(KIND_REG, 5'd12, 1'b0);
        writeback_shuffled();
        wait_drain();
        check_regfile();
        finish_test();

        start_test("store");
        stores_start = stores_done;
        alloc_one(KIND_REG, 5'd9, 1'b0);
        alloc_one(KIND_STORE, '0, 1'b0);
        alloc_one(KIND_REG, 5'd10, 1'b0);
        alloc_one(KIND_STORE, '0, 1'b0);
        alloc_one(KIND_REG, 5'd9, 1'b0);
        writeback_shuffled();
        wait_drain();
        assert (stores_done - stores_start == 2) else plain_error("a store handshake is missing");
        finish_test();

        // everything after the mispredicted branch is squashed
        start_test("branch");
        redirects_start = redirects;
        alloc_one(KIND_REG, 5'd3, 1'b0);
        alloc_one(KIND_BRANCH, '0, 1'b0);
        alloc_one(KIND_REG, 5'd4, 1'b0);
        alloc_one(KIND_BRANCH, '0, 1'b1);
        alloc_one(KIND_REG, 5'd3, 1'b0);
        alloc_one(KIND_STORE, '0, 1'b0);
        alloc_one(KIND_REG, 5'd5, 1'b0);
        writeback_shuffled();
        wait_drain();
        assert (redirects - redirects_start == 1) else plain_error("expected exactly one redirect");
        check_regfile();
        for (int i = 0; i < 4; i++) begin
            alloc_one(KIND_REG, `REG_ADDR_W'(i + 3), 1'b0);
        end
        writeback_shuffled();
        wait_drain();
        check_regfile();
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_top (
    input  wire                       clk,
    input  wire                       rst_n,
    // allocation
    input  wire                       alloc_valid,
    input  wire rob_pkg::entry_kind_e alloc_kind,
    input  wire [`REG_ADDR_W-1:0]     alloc_rd,
    output logic                      alloc_ready,
    output logic [`ROB_TAG_W-1:0]     alloc_tag,
    // writeback
    input  wire                       wb_valid,
    input  wire [`ROB_TAG_W-1:0]      wb_tag,
    input  wire [`XLEN-1:0]           wb_result,
    input  wire                       wb_mispredict,
    // commit
    output logic                      commit_valid,
    output logic [`REG_ADDR_W-1:0]    commit_rd,
    output logic [`XLEN-1:0]          commit_data,
    output logic                      redirect_valid,
    output logic [`XLEN-1:0]          redirect_pc,
    // store port, four-phase
    output logic                      st_req,
    output logic [`XLEN-1:0]          st_data,
    input  wire                       st_ack,
    // register file peek
    input  wire [`REG_ADDR_W-1:0]     rf_rd_addr,
    output logic [`XLEN-1:0]          rf_rd_data
);

    rob_wb_if   wb_bus ();
    rob_head_if hd_bus ();

    logic [`ROB_TAG_W-1:0] head_ptr;
    logic [`ROB_TAG_W-1:0] tail_ptr;
    logic                  full;
    logic                  alloc_fire;

    assign alloc_ready = !full;
    assign alloc_tag   = tail_ptr;
    assign alloc_fire  = alloc_valid && alloc_ready;

    assign wb_bus.valid      = wb_valid;
    assign wb_bus.tag        = wb_tag;
    assign wb_bus.result     = wb_result;
    assign wb_bus.mispredict = wb_mispredict;

    rob_ptr_ctr u_ptr_ctr (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_fire (alloc_fire),
        .hd         (hd_bus.monitor),
        .head_ptr   (head_ptr),
        .tail_ptr   (tail_ptr),
        .full       (full),
        .empty      ()
    );

    rob_entry_store u_entry_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_fire (alloc_fire),
        .alloc_kind (alloc_kind),
        .alloc_rd   (alloc_rd),
        .tail_ptr   (tail_ptr),
        .head_ptr   (head_ptr),
        .wb         (wb_bus.sink),
        .hd         (hd_bus.source)
    );

    rob_commit_fsm u_commit_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .hd             (hd_bus.control),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .st_req         (st_req),
        .st_data        (st_data),
        .st_ack         (st_ack)
    );

    arch_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (commit_valid),
        .wr_addr (commit_rd),
        .wr_data (commit_data),
        .rd_addr (rf_rd_addr),
        .rd_data (rf_rd_data)
    );

endmodule

`default_nettype wire

// ==== source/arch_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module arch_regfile (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     we,
    input  wire [`REG_ADDR_W-1:0]   wr_addr,
    input  wire [`XLEN-1:0]         wr_data,
    input  wire [`REG_ADDR_W-1:0]   rd_addr,
    output logic [`XLEN-1:0]        rd_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            // x0 is hardwired, never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// ==== source/rob_commit_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_commit_fsm (
    input  wire                      clk,
    input  wire                      rst_n,
    rob_head_if.control              hd,
    output logic                     commit_valid,
    output logic [`REG_ADDR_W-1:0]   commit_rd,
    output logic [`XLEN-1:0]         commit_data,
    output logic                     redirect_valid,
    output logic [`XLEN-1:0]         redirect_pc,
    output logic                     st_req,
    output logic [`XLEN-1:0]         st_data,
    input  wire                      st_ack
);

    import rob_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ST_REQ,
        ST_WAIT_LOW,
        FLUSH
    } state_e;

    state_e     state_q;
    state_e     state_d;
    rob_entry_s head;
    logic       act;
    logic       retire_d;
    logic       retire_q;
    logic       commit_d;

    assign head = hd.head_entry;

    // the head stays in place during the retire cycle, skip it once
    assign act = (state_q == IDLE) && hd.head_valid && !retire_q;

    always_comb begin
        state_d  = state_q;
        retire_d = 1'b0;
        commit_d = 1'b0;
        case (state_q)
            IDLE: begin
                if (act) begin
                    case (head.kind)
                        KIND_REG: begin
                            retire_d = 1'b1;
                            commit_d = 1'b1;
                        end
                        KIND_STORE: begin
                            state_d = ST_REQ;
                        end
                        KIND_BRANCH: begin
                            if (head.mispredict) begin
                                state_d = FLUSH;
                            end else begin
                                retire_d = 1'b1;
                            end
                        end
                        default: retire_d = 1'b1;
                    endcase
                end
            end
            ST_REQ: begin
                if (st_ack) begin
                    state_d = ST_WAIT_LOW;
                end
            end
            ST_WAIT_LOW: begin
                // last phase of the handshake
                if (!st_ack) begin
                    state_d  = IDLE;
                    retire_d = 1'b1;
                end
            end
            FLUSH:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            retire_q     <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            state_q      <= state_d;
            retire_q     <= retire_d;
            commit_valid <= commit_d;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_d) begin
            commit_rd   <= head.rd;
            commit_data <= head.result.reg_value;
        end
    end

    assign hd.retire      = retire_q;
    assign hd.flush       = (state_q == FLUSH);
    assign redirect_valid = (state_q == FLUSH);
    assign redirect_pc    = head.result.redirect_pc;
    assign st_req         = (state_q == ST_REQ);
    assign st_data        = head.result.reg_value;

endmodule

`default_nettype wire

// ==== source/rob_entry_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_entry_store (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      alloc_fire,
    input  wire rob_pkg::entry_kind_e alloc_kind,
    input  wire [`REG_ADDR_W-1:0]    alloc_rd,
    input  wire [`ROB_TAG_W-1:0]     tail_ptr,
    input  wire [`ROB_TAG_W-1:0]     head_ptr,
    rob_wb_if.sink                   wb,
    rob_head_if.source               hd
);

    import rob_pkg::*;

    // control bits per entry
    logic [`ROB_DEPTH-1:0] busy_q;
    logic [`ROB_DEPTH-1:0] done_q;

    // payload per entry
    entry_kind_e            kind_q [`ROB_DEPTH];
    logic [`REG_ADDR_W-1:0] rd_q   [`ROB_DEPTH];
    logic                   mis_q  [`ROB_DEPTH];
    result_u                res_q  [`ROB_DEPTH];

    logic wb_hit;

    // late results for squashed entries are dropped here
    assign wb_hit = wb.valid && busy_q[wb.tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
            done_q <= '0;
        end else if (hd.flush) begin
            busy_q <= '0;
            done_q <= '0;
        end else begin
            if (alloc_fire) begin
                busy_q[tail_ptr] <= 1'b1;
                done_q[tail_ptr] <= 1'b0;
            end
            if (wb_hit) begin
                done_q[wb.tag] <= 1'b1;
            end
            if (hd.retire) begin
                busy_q[head_ptr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            kind_q[tail_ptr] <= alloc_kind;
            rd_q[tail_ptr]   <= alloc_rd;
        end
        if (wb_hit) begin
            res_q[wb.tag] <= wb.result;
            mis_q[wb.tag] <= wb.mispredict;
        end
    end

    // head view
    always_comb begin
        hd.head_entry.busy       = busy_q[head_ptr];
        hd.head_entry.done       = done_q[head_ptr];
        hd.head_entry.kind       = kind_q[head_ptr];
        hd.head_entry.rd         = rd_q[head_ptr];
        hd.head_entry.mispredict = mis_q[head_ptr];
        hd.head_entry.result     = res_q[head_ptr];
    end

    assign hd.head_valid = busy_q[head_ptr] && done_q[head_ptr];

endmodule

`default_nettype wire

// ==== source/rob_ptr_ctr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_ptr_ctr (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    alloc_fire,
    rob_head_if.monitor            hd,
    output logic [`ROB_TAG_W-1:0]  head_ptr,
    output logic [`ROB_TAG_W-1:0]  tail_ptr,
    output logic                   full,
    output logic                   empty
);

    typedef logic [`ROB_TAG_W-1:0] tag_t;
    typedef logic [`ROB_TAG_W:0]   count_t;

    localparam tag_t   LAST_IDX  = tag_t'(`ROB_DEPTH - 1);
    localparam count_t DEPTH_CNT = count_t'(`ROB_DEPTH);

    count_t count;
    logic   retire_ok;

    function automatic tag_t next_ptr(input tag_t p);
        return (p == LAST_IDX) ? '0 : p + 1'b1;
    endfunction

    // a retire on an empty buffer cannot happen, guard anyway
    assign retire_ok = hd.retire && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (hd.flush) begin
            head_ptr <= tail_ptr;
            count    <= '0;
        end else begin
            if (alloc_fire) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (retire_ok) begin
                head_ptr <= next_ptr(head_ptr);
            end
            case ({alloc_fire, retire_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == DEPTH_CNT);
    assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== source/rob_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

// result bus from the execution side
interface rob_wb_if;
    import rob_pkg::*;

    logic                  valid;
    logic [`ROB_TAG_W-1:0] tag;
    result_u               result;
    logic                  mispredict;

    modport source (output valid, tag, result, mispredict);
    modport sink   (input  valid, tag, result, mispredict);
endinterface

// oldest entry and the commit decisions taken on it
interface rob_head_if;
    import rob_pkg::*;

    logic       head_valid;
    rob_entry_s head_entry;
    logic       retire;
    logic       flush;

    modport source  (output head_valid, head_entry, input retire, flush);
    modport control (input head_valid, head_entry, output retire, flush);
    modport monitor (input retire, flush);
endinterface

`default_nettype wire

// ==== source/rob_pkg.sv ====
`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        KIND_REG    = 2'd0,
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2
    } entry_kind_e;

    // one writeback word, read by entry kind
    typedef union packed {
        logic [`XLEN-1:0] reg_value;
        logic [`XLEN-1:0] redirect_pc;
    } result_u;

    typedef struct packed {
        logic                   busy;
        logic                   done;
        entry_kind_e            kind;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   mispredict;
        result_u                result;
    } rob_entry_s;

endpackage

`default_nettype wire

// ==== source/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// reorder buffer geometry
`define ROB_DEPTH   16
`define ROB_TAG_W   4

// datapath
`define XLEN        32

// architectural registers
`define NUM_REGS    32
`define REG_ADDR_W  5

`endif
